// ==== Bender.yml ====
package:
  name: sd_adc_display

sources:
  # design, package first
  - files:
      - verilog/sd_adc_pkg.sv
      - verilog/sd_decimator.sv
      - verilog/box_average.sv
      - verilog/bcd_convert.sv
      - verilog/seg_encode.sv
      - verilog/sd_adc_display.sv

  # testbench
  - target: test
    files:
      - verification/tb_sd_adc_display.sv

// ==== tb.f ====
verilog/sd_adc_pkg.sv
verilog/sd_decimator.sv
verilog/box_average.sv
verilog/bcd_convert.sv
verilog/seg_encode.sv
verilog/sd_adc_display.sv
verification/tb_sd_adc_display.sv

// ==== verification/tb_sd_adc_display.sv ====
`default_nettype none

module tb_sd_adc_display;

	timeunit 1ns;
	timeprecision 100ps;

	import sd_adc_pkg::*;

	localparam int ACCUM_BITS    = 8;	// 256 cycle window
	localparam int AVG_BITS      = 2;	// four windows per value
	localparam int WINDOW        = 1 << ACCUM_BITS;
	localparam int PULSE_GAP     = 1 << (ACCUM_BITS + AVG_BITS);	// 1024 cycles
	localparam int PULSE_TIMEOUT = 2 * PULSE_GAP + 64;	// in clock cycles

	logic           clk = 1'b0;
	logic           rstn = 1'b0;	// held low for two edges
	logic           comp_i = 1'b0;
	logic           feedback_o;
	sample_s        sample_o;
	seg_glyph_e [2:0] seg_o;

	int          duty_ones = 0;	// high cycles per pattern period
	int          duty_period = 1;	// divides the window
	int          phase = 0;
	int          exp_value = 0;	// settled value of current duty
	logic        check_en = 1'b0;	// compare the next pulse
	logic        pulse_seen;	// a filtered value came out
	int          gap;	// cycles since last pulse
	logic [7:0]  last_value;	// value of last pulse
	int          value_errors = 0;
	int          protocol_errors = 0;
	int          timeout_errors = 0;

	sd_adc_display #(
		.ACCUM_BITS(ACCUM_BITS),
		.AVG_BITS  (AVG_BITS)
	) sd_adc_display_i (
		.clk       (clk),
		.rstn      (rstn),
		.comp_i    (comp_i),
		.feedback_o(feedback_o),
		.sample_o  (sample_o),
		.seg_o     (seg_o)
	);

	initial begin
		forever #2 clk = ~clk;	// 4 ns period
	end

	//**************************************************************************
	// reference model from the duty rule and decimal glyphs
	//**************************************************************************

	function automatic int duty_value(input int ones, input int period);
		int count;
		count = (WINDOW * ones) / period;	// ones per window
		if (count > WINDOW - 1)
			count = WINDOW - 1;	// counter saturates
		return count;
	endfunction

	function automatic seg_glyph_e glyph_for(input int digit);
		case (digit)
			0:       return GLYPH_0;
			1:       return GLYPH_1;
			2:       return GLYPH_2;
			3:       return GLYPH_3;
			4:       return GLYPH_4;
			5:       return GLYPH_5;
			6:       return GLYPH_6;
			7:       return GLYPH_7;
			8:       return GLYPH_8;
			9:       return GLYPH_9;
			default: return GLYPH_BLANK;
		endcase
	endfunction

	// hundreds in the top slot, ones in the bottom
	function automatic logic [20:0] expected_glyphs(input int value);
		return {glyph_for(value / 100), glyph_for((value / 10) % 10),
			glyph_for(value % 10)};
	endfunction

	//**************************************************************************
	// comparator stimulus and pulse tracking
	//**************************************************************************

	always @(posedge clk) begin
		if (rstn) begin
			comp_i <= (phase < duty_ones);	// ones at start of period
			phase  <= (phase + 1 >= duty_period) ? 0 : phase + 1;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			pulse_seen <= 1'b0;
			gap        <= 0;
			last_value <= '0;
		end else if (sample_o.valid) begin
			pulse_seen <= 1'b1;
			gap        <= 0;
			last_value <= sample_o.data;	// for the display check
		end else begin
			gap <= gap + 1;
		end
	end

	//**************************************************************************
	// checks
	//**************************************************************************

	a_feedback: assert property (@(posedge clk) disable iff (!rstn)
		feedback_o == $past(comp_i))
	else begin
		protocol_errors++;
		$display("[FAIL] %0d ns: feedback_o does not follow comp_i of the previous cycle",
			$time);
	end

	// idle outputs until the first filtered value
	a_idle: assert property (@(posedge clk) disable iff (!rstn)
		!pulse_seen && !sample_o.valid |->
		sample_o.data == '0 && seg_o == {3{GLYPH_BLANK}} && !feedback_o)
	else begin
		protocol_errors++;
		$display("[FAIL] %0d ns: outputs not idle before first value", $time);
	end

	a_width: assert property (@(posedge clk) disable iff (!rstn)
		sample_o.valid |=> !sample_o.valid)
	else begin
		protocol_errors++;
		$display("[FAIL] %0d ns: sample_o.valid high for more than one cycle", $time);
	end

	a_gap: assert property (@(posedge clk) disable iff (!rstn)
		sample_o.valid && pulse_seen |-> gap == PULSE_GAP - 1)
	else begin
		protocol_errors++;
		$display("[FAIL] %0d ns: pulse gap %0d cycles, expected %0d", $time,
			$sampled(gap) + 1, PULSE_GAP);
	end

	a_value: assert property (@(posedge clk) disable iff (!rstn)
		sample_o.valid && check_en |-> sample_o.data == exp_value)
	else begin
		value_errors++;
		$display("[FAIL] %0d ns: sample value %0d, expected %0d", $time,
			$sampled(sample_o.data), exp_value);
	end

	// display follows every value two cycles later
	a_display: assert property (@(posedge clk) disable iff (!rstn)
		sample_o.valid |-> ##2 seg_o == expected_glyphs(last_value))
	else begin
		value_errors++;
		$display("[FAIL] %0d ns: glyphs %h, expected %h for value %0d", $time,
			$sampled(seg_o), expected_glyphs(last_value), last_value);
	end

	a_settled_display: assert property (@(posedge clk) disable iff (!rstn)
		sample_o.valid && check_en |-> ##2 seg_o == expected_glyphs(exp_value))
	else begin
		value_errors++;
		$display("[FAIL] %0d ns: glyphs %h, expected %h for duty value %0d", $time,
			$sampled(seg_o), expected_glyphs(exp_value), exp_value);
	end

	//**************************************************************************
	// sequence
	//**************************************************************************

	task automatic finish_run();
		$display("errors: %0d value, %0d protocol, %0d timeout",
			value_errors, protocol_errors, timeout_errors);
		if (value_errors + protocol_errors + timeout_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	endtask

	// returns on the edge that samples the pulse
	task automatic wait_pulse();
		int waited;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!sample_o.valid && waited < PULSE_TIMEOUT);
		if (!sample_o.valid) begin
			timeout_errors++;
			$display("timeout: sample_o.valid did not pulse within %0d cycles", PULSE_TIMEOUT);
			finish_run();
		end else begin
			@(posedge clk);
		end
	endtask

	task automatic run_duty(input int ones, input int period);
		@(posedge clk);
		duty_ones   <= ones;
		duty_period <= period;
		wait_pulse();	// mixed group
		wait_pulse();	// settling margin
		exp_value = duty_value(ones, period);	// checks of the previous duty have ended
		check_en <= 1'b1;
		wait_pulse();
		check_en <= 1'b0;
	endtask

	initial begin
		repeat (2) @(posedge clk);
		rstn <= 1'b1;
		run_duty(0, 1);	// constant low settles at 0
		run_duty(1, 1);	// constant high saturates at 255
		run_duty(1, 4);	// 64
		run_duty(3, 8);	// 96
		repeat (3) @(posedge clk);	// display checks end two edges after the pulse
		finish_run();
	end

endmodule

`default_nettype wire

// ==== verilog/bcd_convert.sv ====
`default_nettype none

module bcd_convert (
	input  wire logic                clk,
	input  wire logic                rstn,	// async, active low
	input  wire sd_adc_pkg::sample_s average_i,	// filtered value
	output sd_adc_pkg::bcd_digits_s  digits_o	// hundreds, tens, ones
);

	import sd_adc_pkg::*;

	localparam int BCD_W = 12;	// three nibbles

	logic [BCD_W-1:0] work;	// double dabble scratch
	logic [BCD_W-1:0] bcd_q;	// registered digits
	logic             valid_q;

	//**************************************************************************
	// shift and add three, one pass per input bit
	//**************************************************************************

	always_comb begin
		work = '0;
		for (int i = SAMPLE_W - 1; i >= 0; i--) begin
			if (work[11:8] >= 4'd5)
				work[11:8] = work[11:8] + 4'd3;	// hundreds
			if (work[7:4] >= 4'd5)
				work[7:4] = work[7:4] + 4'd3;	// tens
			if (work[3:0] >= 4'd5)
				work[3:0] = work[3:0] + 4'd3;	// ones
			work = {work[BCD_W-2:0], average_i.data[i]};	// next bit in at lsb
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= average_i.valid;	// one cycle stage
		end
	end

	always_ff @(posedge clk) begin
		bcd_q <= work;	// digits ride along with valid_q
	end

	assign digits_o.valid    = valid_q;
	assign digits_o.hundreds = bcd_q[11:8];
	assign digits_o.tens     = bcd_q[7:4];
	assign digits_o.ones     = bcd_q[3:0];

endmodule

`default_nettype wire

// ==== verilog/box_average.sv ====
`default_nettype none

module box_average #(
	parameter int AVG_BITS = 3	// log2 of samples per group
) (
	input  wire logic                clk,
	input  wire logic                rstn,	// async, active low
	input  wire sd_adc_pkg::sample_s sample_i,	// raw decimator samples
	output sd_adc_pkg::sample_s      average_o	// one value per group
);

	import sd_adc_pkg::*;

	sample_s                      sample_d1;	// input pipeline stage
	logic [AVG_BITS-1:0]          count_q;	// position inside group
	logic [SAMPLE_W+AVG_BITS-1:0] accum_q;	// running group sum
	logic [SAMPLE_W+AVG_BITS-1:0] group_sum;	// sum including current sample
	logic                         group_done;	// last sample of group
	logic [SAMPLE_W-1:0]          avg_q;	// held filtered value
	logic                         valid_q;

	// first sample of a group primes the sum
	assign group_sum  = (count_q == '0) ? (SAMPLE_W + AVG_BITS)'(sample_d1.data) :
		accum_q + (SAMPLE_W + AVG_BITS)'(sample_d1.data);
	assign group_done = sample_d1.valid && (&count_q);

	//**************************************************************************
	// input register and group accumulation
	//**************************************************************************

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			sample_d1 <= '0;
			count_q   <= '0;
			accum_q   <= '0;
		end else begin
			sample_d1 <= sample_i;	// strobe used as is
			if (sample_d1.valid) begin
				accum_q <= group_sum;
				count_q <= count_q + 1'b1;	// wraps at group end
			end
		end
	end

	//**************************************************************************
	// result latch, mean is sum >> AVG_BITS
	//**************************************************************************

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			avg_q   <= '0;
			valid_q <= 1'b0;
		end else begin
			if (group_done)
				avg_q <= group_sum[SAMPLE_W+AVG_BITS-1:AVG_BITS];	// divide by 2**AVG_BITS
			valid_q <= group_done;	// two cycles after last input pulse
		end
	end

	assign average_o.valid = valid_q;
	assign average_o.data  = avg_q;

endmodule

`default_nettype wire

// ==== verilog/sd_adc_display.sv ====
`default_nettype none

module sd_adc_display #(
	parameter int ACCUM_BITS = 10,	// decimator window 2**ACCUM_BITS, >= 8
	parameter int AVG_BITS   = 3	// samples per average 2**AVG_BITS
) (
	input  wire logic                    clk,
	input  wire logic                    rstn,	// async, active low
	input  wire logic                    comp_i,	// comparator output
	output logic                         feedback_o,	// to the rc network
	output sd_adc_pkg::sample_s          sample_o,	// filtered value
	output sd_adc_pkg::seg_glyph_e [2:0] seg_o	// ones digit first
);

	import sd_adc_pkg::*;

	sample_s     raw_sample;	// decimator to filter
	bcd_digits_s digits;	// converter to encoder

	//**************************************************************************
	// four stage pipeline
	//**************************************************************************

	sd_decimator #(
		.ACCUM_BITS(ACCUM_BITS)
	) sd_decimator_i (
		.clk       (clk),
		.rstn      (rstn),
		.comp_i    (comp_i),
		.feedback_o(feedback_o),
		.sample_o  (raw_sample)
	);

	box_average #(
		.AVG_BITS(AVG_BITS)
	) box_average_i (
		.clk      (clk),
		.rstn     (rstn),
		.sample_i (raw_sample),
		.average_o(sample_o)	// also feeds the converter
	);

	bcd_convert bcd_convert_i (
		.clk      (clk),
		.rstn     (rstn),
		.average_i(sample_o),
		.digits_o (digits)
	);

	seg_encode seg_encode_i (
		.clk     (clk),
		.rstn    (rstn),
		.digits_i(digits),
		.seg_o   (seg_o)
	);

endmodule

`default_nettype wire

// ==== verilog/sd_adc_pkg.sv ====
`default_nettype none

package sd_adc_pkg;

	// width of one adc sample and of the filtered value
	localparam int SAMPLE_W = 8;	// three decimal digits cover 0..255

	// one sample on a stage link, valid high for a single cycle
	typedef struct packed {
		logic                valid;	// new data this cycle
		logic [SAMPLE_W-1:0] data;	// sample value
	} sample_s;

	// decimal digits of one value, msd first in the packing
	typedef struct packed {
		logic       valid;	// new digits this cycle
		logic [3:0] hundreds;
		logic [3:0] tens;
		logic [3:0] ones;
	} bcd_digits_s;

	// segment patterns, bit 6 is g down to bit 0 a, high lights a segment
	typedef enum logic [6:0] {
		GLYPH_BLANK = 7'h00,	// all segments off
		GLYPH_0     = 7'h3f,
		GLYPH_1     = 7'h06,
		GLYPH_2     = 7'h5b,
		GLYPH_3     = 7'h4f,
		GLYPH_4     = 7'h66,
		GLYPH_5     = 7'h6d,
		GLYPH_6     = 7'h7d,
		GLYPH_7     = 7'h07,
		GLYPH_8     = 7'h7f,
		GLYPH_9     = 7'h6f
	} seg_glyph_e;

endpackage

`default_nettype wire

// ==== verilog/sd_decimator.sv ====
`default_nettype none

module sd_decimator #(
	parameter int ACCUM_BITS = 10	// log2 of window length, at least SAMPLE_W
) (
	input  wire logic                clk,
	input  wire logic                rstn,	// async, active low
	input  wire logic                comp_i,	// comparator output
	output logic                     feedback_o,	// back to the rc network
	output sd_adc_pkg::sample_s      sample_o	// one sample per window
);

	import sd_adc_pkg::*;

	logic                  delta_q;	// captured comparator bit
	logic [ACCUM_BITS-1:0] counter_q;	// free-running window count
	logic                  rollover_q;	// window terminal count
	logic [ACCUM_BITS-1:0] sigma_q;	// ones in current window
	logic [SAMPLE_W-1:0]   accum_q;	// latched window result
	logic                  rdy_q;	// accum_q is new

	//**************************************************************************
	// comparator capture and feedback
	//**************************************************************************

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			delta_q <= 1'b0;
		end else begin
			delta_q <= comp_i;	// one cycle behind comp_i
		end
	end

	assign feedback_o = delta_q;	// closes the modulator loop

	//**************************************************************************
	// window timing
	//**************************************************************************

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			counter_q  <= '0;
			rollover_q <= 1'b0;
		end else begin
			counter_q  <= counter_q + 1'b1;	// wraps every 2**ACCUM_BITS
			rollover_q <= &counter_q;	// high one cycle after all ones
		end
	end

	//**************************************************************************
	// ones accumulator
	//**************************************************************************

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			sigma_q <= '0;
			accum_q <= '0;
			rdy_q   <= 1'b0;
		end else begin
			if (rollover_q) begin
				accum_q <= sigma_q[ACCUM_BITS-1 -: SAMPLE_W];	// keep top bits only
				sigma_q <= ACCUM_BITS'(delta_q);	// restart, current bit counts
			end else if (!(&sigma_q)) begin
				sigma_q <= sigma_q + ACCUM_BITS'(delta_q);	// stops at all ones
			end
			rdy_q <= rollover_q;	// lines up with accum_q
		end
	end

	assign sample_o.valid = rdy_q;
	assign sample_o.data  = accum_q;

endmodule

`default_nettype wire

// ==== verilog/seg_encode.sv ====
`default_nettype none

module seg_encode (
	input  wire logic                    clk,
	input  wire logic                    rstn,	// async, active low
	input  wire sd_adc_pkg::bcd_digits_s digits_i,	// decimal digits
	output sd_adc_pkg::seg_glyph_e [2:0] seg_o	// [0] is the ones digit
);

	import sd_adc_pkg::*;

	// one decimal digit to its segment pattern
	function automatic seg_glyph_e digit_glyph(input logic [3:0] digit);
		case (digit)
			4'd0:    return GLYPH_0;
			4'd1:    return GLYPH_1;
			4'd2:    return GLYPH_2;
			4'd3:    return GLYPH_3;
			4'd4:    return GLYPH_4;
			4'd5:    return GLYPH_5;
			4'd6:    return GLYPH_6;
			4'd7:    return GLYPH_7;
			4'd8:    return GLYPH_8;
			4'd9:    return GLYPH_9;
			default: return GLYPH_BLANK;	// not a decimal digit
		endcase
	endfunction

	//**************************************************************************
	// display register, held between updates
	//**************************************************************************

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			for (int k = 0; k < 3; k++)
				seg_o[k] <= GLYPH_BLANK;	// dark until first value
		end else if (digits_i.valid) begin
			seg_o[0] <= digit_glyph(digits_i.ones);
			seg_o[1] <= digit_glyph(digits_i.tens);
			seg_o[2] <= digit_glyph(digits_i.hundreds);
		end
	end

endmodule

`default_nettype wire
